/* common/mips_pkg.sv */
package mips_pkg;

	// Main opcodes, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00; // Decoded further by funct
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type funct field, instr[5:0]
	localparam logic [5:0] FN_SLL  = 6'h00; // Shift by shamt
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// ALU operation select
	localparam logic [3:0] ALU_ADD  = 4'd0;
	localparam logic [3:0] ALU_SUB  = 4'd1; // Also used for branch compare
	localparam logic [3:0] ALU_AND  = 4'd2;
	localparam logic [3:0] ALU_OR   = 4'd3;
	localparam logic [3:0] ALU_XOR  = 4'd4;
	localparam logic [3:0] ALU_SLT  = 4'd5; // Signed compare
	localparam logic [3:0] ALU_SLTU = 4'd6; // Unsigned compare
	localparam logic [3:0] ALU_SLL  = 4'd7;
	localparam logic [3:0] ALU_SRL  = 4'd8;
	localparam logic [3:0] ALU_SRA  = 4'd9;
	localparam logic [3:0] ALU_LUI  = 4'd10; // Immediate into upper half

	localparam logic [4:0] REG_V0 = 5'd2; // Result register shown at top level

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target; // Word index within 256 MB region
		} j;
	} instr_t;

endpackage

/* common/ctrl_if.sv */
interface ctrl_if;
	logic       reg_write;    // Register file write
	logic       reg_dst_rd;   // Destination is rd, else rt
	logic       link;         // Write back PC + 4
	logic       alu_src_imm;  // ALU b from immediate
	logic       imm_zero_ext; // Zero extend instead of sign extend
	logic       shift_imm;    // Shift amount from shamt field
	logic       mem_read;     // Load word
	logic       mem_write;    // Store word
	logic       branch_eq;
	logic       branch_ne;
	logic       jump;         // 26-bit target jump
	logic       jump_reg;     // Jump to rs
	logic [3:0] alu_op;

	modport dec (
		output reg_write, reg_dst_rd, link, alu_src_imm, imm_zero_ext, shift_imm,
		output mem_read, mem_write, branch_eq, branch_ne, jump, jump_reg, alu_op
	);

	modport dp (
		input reg_write, reg_dst_rd, link, alu_src_imm, imm_zero_ext, shift_imm,
		input mem_read, mem_write, branch_eq, branch_ne, jump, jump_reg, alu_op
	);

endinterface

/* core/alu.sv */
module alu (
	input  logic [3:0]  alu_op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	output logic [31:0] result,
	output logic        zero
);
	import mips_pkg::*;

	logic [31:0] sum;
	logic [31:0] diff;
	logic        lt_signed;
	logic        lt_unsigned;

	assign sum         = a + b;
	assign diff        = a - b;
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (alu_op)
			ALU_ADD:  result = sum;
			ALU_SUB:  result = diff;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_SLT:  result = {31'd0, lt_signed};
			ALU_SLTU: result = {31'd0, lt_unsigned};
			ALU_SLL:  result = b << shamt; // Shifts act on rt
			ALU_SRL:  result = b >> shamt;
			ALU_SRA:  result = $unsigned($signed(b) >>> shamt);
			ALU_LUI:  result = {b[15:0], 16'd0};
			default:  result = 32'd0;
		endcase
	end

	assign zero = (result == 32'd0); // BEQ/BNE after subtract

endmodule

/* core/reg_file.sv */
module reg_file (
	input  logic        clk,
	input  logic        reset,
	input  logic        write_en,
	input  logic [4:0]  read_addr_a,
	input  logic [4:0]  read_addr_b,
	input  logic [4:0]  write_addr,
	input  logic [31:0] write_data,
	output logic [31:0] read_data_a,
	output logic [31:0] read_data_b,
	output logic [31:0] v0
);
	import mips_pkg::*;

	logic [31:0] regs [32];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= 32'd0;
			end
		end else if (write_en && write_addr != 5'd0) begin // r0 write dropped
			regs[write_addr] <= write_data;
		end
	end

	// Combinational reads, r0 forced to zero
	assign read_data_a = (read_addr_a == 5'd0) ? 32'd0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == 5'd0) ? 32'd0 : regs[read_addr_b];

	assign v0 = regs[REG_V0];

endmodule

/* core/control_unit.sv */
module control_unit (
	input mips_pkg::instr_t instr,
	ctrl_if.dec             ctrl
);
	import mips_pkg::*;

	always_comb begin
		// Default is a no-op: nothing written, no bus access
		ctrl.reg_write    = 1'b0;
		ctrl.reg_dst_rd   = 1'b0;
		ctrl.link         = 1'b0;
		ctrl.alu_src_imm  = 1'b0;
		ctrl.imm_zero_ext = 1'b0;
		ctrl.shift_imm    = 1'b0;
		ctrl.mem_read     = 1'b0;
		ctrl.mem_write    = 1'b0;
		ctrl.branch_eq    = 1'b0;
		ctrl.branch_ne    = 1'b0;
		ctrl.jump         = 1'b0;
		ctrl.jump_reg     = 1'b0;
		ctrl.alu_op       = ALU_ADD;

		case (instr.r.op)
			OP_RTYPE: begin
				ctrl.reg_dst_rd = 1'b1;
				ctrl.reg_write  = 1'b1; // Cleared below for JR and unknown funct
				case (instr.r.funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_SLTU: ctrl.alu_op = ALU_SLTU;
					FN_SLL: begin
						ctrl.alu_op    = ALU_SLL;
						ctrl.shift_imm = 1'b1;
					end
					FN_SRL: begin
						ctrl.alu_op    = ALU_SRL;
						ctrl.shift_imm = 1'b1;
					end
					FN_SRA: begin
						ctrl.alu_op    = ALU_SRA;
						ctrl.shift_imm = 1'b1;
					end
					FN_JR: begin
						ctrl.reg_write = 1'b0; // Plain return, no link
						ctrl.jump_reg  = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				case (instr.i.op)
					OP_SLTI:  ctrl.alu_op = ALU_SLT;
					OP_SLTIU: ctrl.alu_op = ALU_SLTU; // Sign-extended imm, unsigned compare
					OP_ANDI: begin
						ctrl.alu_op       = ALU_AND;
						ctrl.imm_zero_ext = 1'b1;
					end
					OP_ORI: begin
						ctrl.alu_op       = ALU_OR;
						ctrl.imm_zero_ext = 1'b1;
					end
					OP_XORI: begin
						ctrl.alu_op       = ALU_XOR;
						ctrl.imm_zero_ext = 1'b1;
					end
					OP_LUI: begin
						ctrl.alu_op       = ALU_LUI;
						ctrl.imm_zero_ext = 1'b1;
					end
					default: ctrl.alu_op = ALU_ADD; // ADDIU
				endcase
			end
			OP_LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1; // Base + offset
				ctrl.mem_read    = 1'b1;
			end
			OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			OP_BEQ: begin
				ctrl.alu_op    = ALU_SUB; // Zero flag gives equality
				ctrl.branch_eq = 1'b1;
			end
			OP_BNE: begin
				ctrl.alu_op    = ALU_SUB;
				ctrl.branch_ne = 1'b1;
			end
			OP_J:    ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump      = 1'b1;
				ctrl.link      = 1'b1; // r31 gets PC + 4
				ctrl.reg_write = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* core/datapath.sv */
module datapath #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0004
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             clk_enable,
	input  mips_pkg::instr_t instr,
	input  logic [31:0]      data_readdata,
	input  logic             data_ack,
	ctrl_if.dp               ctrl,
	output logic             active,
	output logic [31:0]      register_v0,
	output logic [31:0]      instr_address,
	output logic [31:0]      data_address,
	output logic [31:0]      data_writedata,
	output logic             data_cyc,
	output logic             data_stb,
	output logic             data_we,
	output logic [3:0]       data_sel
);

	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] pc_branch;
	logic [31:0] pc_jump;
	logic [31:0] pc_next;
	logic        bus_done;    // Ack seen last cycle, keep cyc low one cycle
	logic        mem_access;
	logic        retire;      // Instruction completes at this edge
	logic        take_branch;
	logic [31:0] imm_ext;
	logic [31:0] rd_a;
	logic [31:0] rd_b;
	logic [31:0] alu_b;
	logic [4:0]  alu_shamt;
	logic [31:0] alu_result;
	logic        alu_zero;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	assign instr_address = pc;
	assign pc_plus4      = pc + 32'd4;

	// Immediate extension and ALU operands
	assign imm_ext   = ctrl.imm_zero_ext ? {16'd0, instr.i.imm}
		: {{16{instr.i.imm[15]}}, instr.i.imm};
	assign alu_b     = ctrl.alu_src_imm ? imm_ext : rd_b;
	assign alu_shamt = ctrl.shift_imm ? instr.r.shamt : rd_a[4:0];

	// Next PC, no delay slot
	assign pc_branch   = pc_plus4 + {imm_ext[29:0], 2'b00};
	assign pc_jump     = {pc_plus4[31:28], instr.j.target, 2'b00};
	assign take_branch = (ctrl.branch_eq & alu_zero) | (ctrl.branch_ne & ~alu_zero);

	always_comb begin
		if (ctrl.jump_reg)
			pc_next = rd_a;
		else if (ctrl.jump)
			pc_next = pc_jump;
		else if (take_branch)
			pc_next = pc_branch;
		else
			pc_next = pc_plus4;
	end

	// Wishbone data master, one access in flight
	assign mem_access     = ctrl.mem_read | ctrl.mem_write;
	assign data_cyc       = active & mem_access & ~bus_done;
	assign data_stb       = data_cyc;
	assign data_we        = data_cyc & ctrl.mem_write;
	assign data_address   = alu_result;
	assign data_writedata = rd_b;
	assign data_sel       = 4'hf; // Word accesses only

	// Memory ops hold the PC until ack
	assign retire = active & clk_enable & (~mem_access | (data_cyc & data_ack));

	// Write-back selection
	assign wb_addr = ctrl.reg_dst_rd ? instr.r.rd : (ctrl.link ? 5'd31 : instr.r.rt); // r31 = ra
	assign wb_data = ctrl.link ? pc_plus4 : (ctrl.mem_read ? data_readdata : alu_result);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pc       <= RESET_VECTOR;
			active   <= 1'b1;
			bus_done <= 1'b0;
		end else if (clk_enable) begin
			bus_done <= data_cyc & data_ack;
			if (retire) begin
				pc <= pc_next;
				if (pc_next == 32'd0)
					active <= 1'b0; // Jump to zero halts
			end
		end
	end

	reg_file u_reg_file (
		.clk         (clk),
		.reset       (reset),
		.write_en    (ctrl.reg_write & retire),
		.read_addr_a (instr.r.rs),
		.read_addr_b (instr.r.rt),
		.write_addr  (wb_addr),
		.write_data  (wb_data),
		.read_data_a (rd_a),
		.read_data_b (rd_b),
		.v0          (register_v0)
	);

	alu u_alu (
		.alu_op (ctrl.alu_op),
		.a      (rd_a),
		.b      (alu_b),
		.shamt  (alu_shamt),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// Cycle released the clock after an accepted ack
	assert property (@(posedge clk) disable iff (reset)
		data_cyc && data_ack && clk_enable |=> !data_cyc)
		else $error("datapath: cyc still high after ack");

	// Request held steady while the slave stalls
	assert property (@(posedge clk) disable iff (reset)
		data_stb && !data_ack |=> data_stb && $stable(data_address)
			&& $stable(data_we) && $stable(data_writedata))
		else $error("datapath: bus request changed before ack");

endmodule

/* rtl/mips_harvard.sv */
module mips_harvard #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0004 // Jump to 0 means halt
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	output logic        active,
	output logic [31:0] register_v0,

	output logic [31:0] instr_address,  // Current PC
	input  logic [31:0] instr_readdata, // Same-cycle instruction word

	output logic        data_cyc,
	output logic        data_stb,
	output logic        data_we,
	output logic [3:0]  data_sel,
	output logic [31:0] data_address,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata,
	input  logic        data_ack
);

	ctrl_if ctrl_bus ();

	control_unit u_control_unit (
		.instr (instr_readdata),
		.ctrl  (ctrl_bus.dec)
	);

	datapath #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_datapath (
		.clk            (clk),
		.reset          (reset),
		.clk_enable     (clk_enable),
		.instr          (instr_readdata),
		.data_readdata  (data_readdata),
		.data_ack       (data_ack),
		.ctrl           (ctrl_bus.dp),
		.active         (active),
		.register_v0    (register_v0),
		.instr_address  (instr_address),
		.data_address   (data_address),
		.data_writedata (data_writedata),
		.data_cyc       (data_cyc),
		.data_stb       (data_stb),
		.data_we        (data_we),
		.data_sel       (data_sel)
	);

endmodule

/* tests/tb_mem_models.sv */
// Combinational instruction ROM, 256 words, loaded by the testbench
module inst_rom (
	input  logic [31:0] address,
	output logic [31:0] readdata
);
	logic [31:0] mem [256];

	assign readdata = mem[address[9:2]]; // Word index
endmodule

// Wishbone classic slave RAM with random wait states
module wb_data_ram (
	input  logic        clk,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [31:0] address,
	input  logic [31:0] writedata,
	output logic [31:0] readdata,
	output logic        ack
);
	logic [31:0] mem [256];
	logic [1:0]  wait_cnt;   // Cycles left before ack
	logic        req_q;      // Unacked request seen last edge
	logic [31:0] addr_q;
	logic        we_q;
	int          protocol_errors = 0;

	assign readdata = mem[address[9:2]];

	always @(posedge clk, posedge reset) begin
		if (reset) begin
			ack      <= 1'b0;
			wait_cnt <= 2'd0;
			for (int k = 0; k < 256; k++) begin
				mem[k] <= 32'd0; // RAM cleared on every reset
			end
		end else if (ack) begin
			ack      <= 1'b0; // Single-cycle ack
			wait_cnt <= 2'($urandom % 4);
		end else if (cyc && stb) begin
			if (wait_cnt == 2'd0) begin
				ack <= 1'b1;
				if (we)
					mem[address[9:2]] <= writedata;
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

	// Master must hold its request steady until ack
	always @(posedge clk) begin
		if (reset) begin
			req_q <= 1'b0;
		end else begin
			if (req_q && !(cyc && stb && address == addr_q && we == we_q)) begin
				$display("Wishbone violation at time %0t: request dropped or changed before ack",
					$time);
				protocol_errors <= protocol_errors + 1;
			end
			req_q  <= cyc && stb && !ack;
			addr_q <= address;
			we_q   <= we;
		end
	end
endmodule

/* tests/tb_mips_harvard.sv */
module tb_mips_harvard;
	import mips_pkg::*;

	localparam int NUM_ROWS = 5;
	localparam int MAX_LEN  = 32;

	logic        clk;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic        data_cyc;
	logic        data_stb;
	logic        data_we;
	logic [3:0]  data_sel;
	logic [31:0] data_address;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;
	logic        data_ack;

	logic [31:0] prog [NUM_ROWS][MAX_LEN]; // Assembled programs
	int          prog_len [NUM_ROWS];
	logic [31:0] exp_v0 [NUM_ROWS];
	logic [31:0] exp_addr [NUM_ROWS];      // RAM byte address checked
	logic [31:0] exp_mem [NUM_ROWS];
	logic        exp_store [NUM_ROWS];     // Else the word must stay zero
	int          checks;
	int          errors;
	int          cycles;
	int          cycle_limit;

	mips_harvard #(.RESET_VECTOR(32'h0000_0004)) i_mips_harvard (
		.clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
		.register_v0(register_v0), .instr_address(instr_address),
		.instr_readdata(instr_readdata), .data_cyc(data_cyc), .data_stb(data_stb),
		.data_we(data_we), .data_sel(data_sel), .data_address(data_address),
		.data_writedata(data_writedata), .data_readdata(data_readdata), .data_ack(data_ack)
	);

	inst_rom rom (.address(instr_address), .readdata(instr_readdata));

	wb_data_ram ram (
		.clk(clk), .reset(reset), .cyc(data_cyc), .stb(data_stb), .we(data_we),
		.address(data_address), .writedata(data_writedata),
		.readdata(data_readdata), .ack(data_ack)
	);

	always #4 clk = ~clk;

	always @(negedge clk) begin
		clk_enable <= ($urandom % 8) != 0; // Stall roughly one cycle in eight
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: run went past %0d cycles without the program halting", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// MIPS instruction formats
	function automatic logic [31:0] enc_r(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] shamt);
		return {OP_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(logic [5:0] op, logic [31:0] addr);
		return {op, addr[27:2]};
	endfunction

	task automatic add_word(input int row, input logic [31:0] word);
		prog[row][prog_len[row]] = word;
		prog_len[row]++;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] time %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic build_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			prog_len[r]  = 0;
			exp_addr[r]  = 32'h48;
			exp_mem[r]   = 32'd0;
			exp_store[r] = 1'b0;
		end
		// Row 0: R-type ops folded into v0
		add_word(0, enc_i(OP_ORI, 0, 8, 16'h00f0));
		add_word(0, enc_i(OP_ORI, 0, 9, 16'h0033));
		add_word(0, enc_i(OP_LUI, 0, 10, 16'h8000));
		add_word(0, enc_r(FN_ADDU, 8, 9, 2, 0));   // 0x123
		add_word(0, enc_r(FN_SUBU, 9, 8, 11, 0));
		add_word(0, enc_r(FN_ADDU, 2, 11, 2, 0));  // 0x66
		add_word(0, enc_r(FN_AND, 8, 9, 11, 0));
		add_word(0, enc_r(FN_XOR, 2, 11, 2, 0));   // 0x56
		add_word(0, enc_r(FN_OR, 8, 9, 11, 0));
		add_word(0, enc_r(FN_ADDU, 2, 11, 2, 0));  // 0x149
		add_word(0, enc_r(FN_XOR, 8, 9, 11, 0));
		add_word(0, enc_r(FN_ADDU, 2, 11, 2, 0));  // 0x20c
		add_word(0, enc_r(FN_SLT, 10, 8, 11, 0));  // Negative < positive
		add_word(0, enc_r(FN_SLL, 0, 11, 11, 4));
		add_word(0, enc_r(FN_ADDU, 2, 11, 2, 0));  // 0x21c
		add_word(0, enc_r(FN_SLTU, 8, 10, 11, 0));
		add_word(0, enc_r(FN_ADDU, 2, 11, 2, 0));  // 0x21d
		add_word(0, enc_r(FN_SRA, 0, 10, 11, 4));  // 0xf8000000
		add_word(0, enc_r(FN_SRL, 0, 10, 12, 4));  // 0x08000000
		add_word(0, enc_r(FN_XOR, 11, 12, 11, 0));
		add_word(0, enc_r(FN_ADDU, 2, 11, 2, 0));
		add_word(0, enc_j(OP_J, 32'd0));
		exp_v0[0] = 32'hf000_021d;
		// Row 1: immediate extension rules
		add_word(1, enc_i(OP_ADDIU, 0, 2, 16'hfffd)); // -3
		add_word(1, enc_i(OP_SLTI, 0, 11, 16'hfffe)); // 0 < -2 is false
		add_word(1, enc_i(OP_ANDI, 2, 12, 16'hfff0)); // 0xfff0
		add_word(1, enc_i(OP_ORI, 0, 13, 16'h8001));
		add_word(1, enc_i(OP_XORI, 12, 14, 16'h8000)); // 0x7ff0
		add_word(1, enc_i(OP_LUI, 0, 15, 16'h1234));
		add_word(1, enc_i(OP_ADDIU, 2, 16, 16'h0005)); // 2
		add_word(1, enc_r(FN_ADDU, 11, 12, 2, 0));
		add_word(1, enc_r(FN_ADDU, 2, 13, 2, 0));
		add_word(1, enc_r(FN_ADDU, 2, 14, 2, 0));
		add_word(1, enc_r(FN_ADDU, 2, 15, 2, 0));
		add_word(1, enc_r(FN_ADDU, 2, 16, 2, 0));
		add_word(1, enc_j(OP_J, 32'd0));
		exp_v0[1] = 32'h1235_ffe3;
		// Row 2: store then load over the bus
		add_word(2, enc_i(OP_LUI, 0, 8, 16'hcafe));
		add_word(2, enc_i(OP_ORI, 8, 8, 16'hbabe));
		add_word(2, enc_i(OP_ADDIU, 0, 9, 16'h0040));
		add_word(2, enc_i(OP_SW, 9, 8, 16'h0008));  // 0x48
		add_word(2, enc_i(OP_SW, 9, 0, 16'h000c));  // 0x4c gets zero
		add_word(2, enc_i(OP_LW, 9, 2, 16'h0008));
		add_word(2, enc_j(OP_J, 32'd0));
		exp_v0[2]    = 32'hcafe_babe;
		exp_mem[2]   = 32'hcafe_babe;
		exp_store[2] = 1'b1;
		// Row 3: branches and jump, markers add to v0
		add_word(3, enc_i(OP_ADDIU, 0, 8, 16'd5));
		add_word(3, enc_i(OP_ADDIU, 0, 9, 16'd5));
		add_word(3, enc_i(OP_ADDIU, 0, 2, 16'd0));
		add_word(3, enc_i(OP_BEQ, 8, 9, 16'd1));    // Taken
		add_word(3, enc_i(OP_ADDIU, 2, 2, 16'd1));
		add_word(3, enc_i(OP_ADDIU, 2, 2, 16'd2));
		add_word(3, enc_i(OP_BNE, 8, 9, 16'd1));    // Not taken
		add_word(3, enc_i(OP_ADDIU, 2, 2, 16'd4));
		add_word(3, enc_i(OP_BEQ, 8, 0, 16'd1));    // Not taken
		add_word(3, enc_i(OP_ADDIU, 2, 2, 16'd8));
		add_word(3, enc_i(OP_BNE, 8, 0, 16'd1));    // Taken
		add_word(3, enc_i(OP_ADDIU, 2, 2, 16'd16));
		add_word(3, enc_j(OP_J, 32'd60));           // Over next word
		add_word(3, enc_i(OP_ADDIU, 2, 2, 16'd32));
		add_word(3, enc_i(OP_ADDIU, 2, 2, 16'd64));
		add_word(3, enc_j(OP_J, 32'd0));
		exp_v0[3] = 32'd78;
		// Row 4: call, return, halt
		add_word(4, enc_i(OP_ADDIU, 0, 2, 16'd1));  // 0x04
		add_word(4, enc_j(OP_JAL, 32'd20));         // 0x08, ra = 0x0c
		add_word(4, enc_r(FN_ADDU, 2, 31, 2, 0));   // 0x0c
		add_word(4, enc_j(OP_J, 32'd0));
		add_word(4, enc_r(FN_SLL, 0, 2, 2, 3));     // 0x14
		add_word(4, enc_i(OP_ADDIU, 2, 2, 16'd5));
		add_word(4, enc_r(FN_JR, 31, 0, 0, 0));
		exp_v0[4] = 32'd25;
	endtask

	task automatic run_row(input int row);
		@(negedge clk);
		reset = 1'b1; // Also clears the RAM
		for (int k = 0; k < 256; k++) begin
			rom.mem[k] = 32'd0;
		end
		rom.mem[0] = enc_i(OP_SW, 0, 2, 16'h0048); // Store parked at halt address
		for (int k = 0; k < prog_len[row]; k++) begin
			rom.mem[k + 1] = prog[row][k]; // Program starts at 0x4
		end
		repeat (3) @(negedge clk);
		reset = 1'b0;
		#1;
		check_value("active", 32'd1, {31'd0, active});
		check_value("instr_address", 32'd4, instr_address);
		check_value("data_cyc", 32'd0, {31'd0, data_cyc});
		check_value("data_stb", 32'd0, {31'd0, data_stb});
		check_value("data_we", 32'd0, {31'd0, data_we});
		check_value("data_sel", 32'hf, {28'd0, data_sel});
		while (active) @(negedge clk);
		check_value("register_v0", exp_v0[row], register_v0);
		check_value("ram word", exp_store[row] ? exp_mem[row] : 32'd0,
			ram.mem[exp_addr[row][9:2]]);
		repeat (5) begin
			@(negedge clk);
			check_value("data_cyc after halt", 32'd0, {31'd0, data_cyc});
		end
		check_value("active after halt", 32'd0, {31'd0, active});
	endtask

	initial begin
		void'($urandom(7));
		clk         = 1'b0;
		reset       = 1'b1;
		clk_enable  = 1'b1;
		checks      = 0;
		errors      = 0;
		cycles      = 0;
		cycle_limit = 0;
		build_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			cycle_limit += prog_len[r] * 5 + 20;
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		errors += ram.protocol_errors;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* all.f */
common/mips_pkg.sv
common/ctrl_if.sv
core/alu.sv
core/reg_file.sv
core/control_unit.sv
core/datapath.sv
rtl/mips_harvard.sv
tests/tb_mem_models.sv
tests/tb_mips_harvard.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tb_mips_harvard \
	-f all.f \
	-o sim_tb_mips_harvard

./obj_dir/sim_tb_mips_harvard > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	exit 1
fi
exit 0
